// ==== include/pipe_config.svh ====
/*
 * Sizes and instruction field positions for the integer pipeline.
 * Included by the package and by any module that slices fields.
 */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath
`define PIPE_XLEN    32     // Data word width
`define PIPE_NREGS   32     // Register file depth
`define PIPE_RA_W    5      // Register address width

// Instruction word layout
`define PIPE_OP_MSB  31     // Opcode field top bit
`define PIPE_OP_LSB  28     // Opcode field bottom bit
`define PIPE_RD_LSB  23     // rd occupies 27..23
`define PIPE_RS1_LSB 18     // rs1 occupies 22..18
`define PIPE_RS2_LSB 13     // rs2 occupies 17..13
`define PIPE_IMM_W   13     // Signed immediate in 12..0

`endif

// ==== design/pipe_pkg.sv ====
/*
 * Shared types of the integer pipeline: data word, register address
 * and the opcode encoding. Referenced by scoped names only.
 */
`default_nettype none
`include "pipe_config.svh"

package pipe_pkg;

    typedef logic [`PIPE_XLEN-1:0] word_t;      // One data word
    typedef logic [`PIPE_RA_W-1:0] gpr_addr_t;  // One register address

    // Values above OP_SW decode as OP_NOP
    typedef enum logic [`PIPE_OP_MSB-`PIPE_OP_LSB:0] {
        OP_NOP  = 4'd0,     // No operation, still retires
        OP_ADD  = 4'd1,     // rd = rs1 + rs2
        OP_SUB  = 4'd2,     // rd = rs1 - rs2
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,     // rd = rs1 + imm
        OP_LW   = 4'd7,     // rd = mem[rs1 + imm]
        OP_SW   = 4'd8      // mem[rs1 + imm] = rs2
    } opcode_e;

endpackage

`default_nettype wire

// ==== design/pipe_gprs.sv ====
/*
 * General purpose registers. Two combinational read ports and one
 * write port; r0 always reads zero.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module pipe_gprs (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire pipe_pkg::gpr_addr_t rs1_addr,
    input  wire pipe_pkg::gpr_addr_t rs2_addr,
    input  wire                      rd_wen,     // One write per clock
    input  wire pipe_pkg::gpr_addr_t rd_addr,
    input  wire pipe_pkg::word_t     rd_wdata,
    output pipe_pkg::word_t          rs1_rdata,
    output pipe_pkg::word_t          rs2_rdata
);

    pipe_pkg::word_t regs [`PIPE_NREGS];

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                regs[i] <= '0;                   // Known state after reset
            end
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_wdata;           // r0 writes dropped
        end
    end

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== design/pipe_decode.sv ====
/*
 * Issue and decode stage. Splits the issued word into fields, picks up
 * forwarded operands and loads the decode-to-execute register, or
 * sends an empty slot forward while a load hazard is pending.
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_config.svh"

module pipe_decode (
    input  wire                  g_clk,
    input  wire                  rst,
    input  wire                  issue_valid,    // Issue word present
    input  wire pipe_pkg::word_t issue_instr,
    input  wire                  s1_bubble,      // Hold input, send empty slot
    input  wire pipe_pkg::word_t fwd_rs1_rdata,  // Operand A after forwarding
    input  wire pipe_pkg::word_t fwd_rs2_rdata,  // Operand B after forwarding
    input  wire                  s2_busy,        // Execute holding
    output logic                 issue_busy,
    output pipe_pkg::gpr_addr_t  s1_rs1_addr,    // Zero when unused
    output pipe_pkg::gpr_addr_t  s1_rs2_addr,
    output logic                 s2_valid,
    output pipe_pkg::opcode_e    s2_op,
    output pipe_pkg::gpr_addr_t  s2_rd,
    output pipe_pkg::word_t      s2_opr_a,
    output pipe_pkg::word_t      s2_opr_b,       // rs2 value, store data on SW
    output pipe_pkg::word_t      s2_imm,         // Sign extended
    output pipe_pkg::word_t      s2_instr
);

    logic [`PIPE_OP_MSB-`PIPE_OP_LSB:0] raw_op;
    pipe_pkg::opcode_e dec_op;
    logic              use_rs1;
    logic              use_rs2;
    logic              accept;                   // Word taken this edge

    assign raw_op = issue_instr[`PIPE_OP_MSB:`PIPE_OP_LSB];

    always_comb begin
        if (raw_op <= pipe_pkg::OP_SW) begin
            dec_op = pipe_pkg::opcode_e'(raw_op);
        end else begin
            dec_op = pipe_pkg::OP_NOP;           // Unknown codes do nothing
        end
    end

    assign use_rs1 = dec_op != pipe_pkg::OP_NOP;
    assign use_rs2 = dec_op inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
                                    pipe_pkg::OP_OR, pipe_pkg::OP_XOR, pipe_pkg::OP_SW};

    // Unused sources read as r0 so they never raise a hazard
    assign s1_rs1_addr = (issue_valid && use_rs1) ?
                         issue_instr[`PIPE_RS1_LSB +: `PIPE_RA_W] : '0;
    assign s1_rs2_addr = (issue_valid && use_rs2) ?
                         issue_instr[`PIPE_RS2_LSB +: `PIPE_RA_W] : '0;

    assign issue_busy = s1_bubble || s2_busy;
    assign accept     = issue_valid && !issue_busy;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (!s2_busy) begin
            s2_valid <= accept;                  // Bubble leaves an empty slot
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            s2_op    <= dec_op;
            s2_rd    <= issue_instr[`PIPE_RD_LSB +: `PIPE_RA_W];
            s2_opr_a <= fwd_rs1_rdata;
            s2_opr_b <= fwd_rs2_rdata;
            s2_imm   <= {{(`PIPE_XLEN-`PIPE_IMM_W){issue_instr[`PIPE_IMM_W-1]}},
                         issue_instr[`PIPE_IMM_W-1:0]};
            s2_instr <= issue_instr;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_hazard_ctrl.sv ====
/*
 * Hazard unit. Compares decode's sources with the rd of each later
 * stage, forwards the youngest match and requests a bubble when the
 * match is a load whose data is not back yet.
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_hazard_ctrl (
    input  wire pipe_pkg::gpr_addr_t s1_rs1_addr,
    input  wire pipe_pkg::gpr_addr_t s1_rs2_addr,
    input  wire pipe_pkg::word_t     s1_rs1_rdata,   // Register file values
    input  wire pipe_pkg::word_t     s1_rs2_rdata,
    input  wire pipe_pkg::gpr_addr_t fwd_s2_rd,      // Execute
    input  wire pipe_pkg::word_t     fwd_s2_wdata,
    input  wire                      fwd_s2_load,
    input  wire pipe_pkg::gpr_addr_t fwd_s3_rd,      // Memory
    input  wire pipe_pkg::word_t     fwd_s3_wdata,
    input  wire                      fwd_s3_load,
    input  wire                      gpr_wen,        // Writeback
    input  wire pipe_pkg::gpr_addr_t gpr_rd,
    input  wire pipe_pkg::word_t     gpr_wdata,
    input  wire                      fwd_s4_load,
    output pipe_pkg::word_t          fwd_rs1_rdata,
    output pipe_pkg::word_t          fwd_rs2_rdata,
    output logic                     s1_bubble
);

    // Source r0 never matches, so empty stages report rd zero
    function automatic logic hit(input pipe_pkg::gpr_addr_t src,
                                 input pipe_pkg::gpr_addr_t dst);
        return (src != '0) && (src == dst);
    endfunction

    logic hzd_rs1_s2;
    logic hzd_rs1_s3;
    logic hzd_rs1_s4;
    logic hzd_rs2_s2;
    logic hzd_rs2_s3;
    logic hzd_rs2_s4;

    assign hzd_rs1_s2 = hit(s1_rs1_addr, fwd_s2_rd);
    assign hzd_rs1_s3 = hit(s1_rs1_addr, fwd_s3_rd);
    assign hzd_rs1_s4 = hit(s1_rs1_addr, gpr_rd);
    assign hzd_rs2_s2 = hit(s1_rs2_addr, fwd_s2_rd);
    assign hzd_rs2_s3 = hit(s1_rs2_addr, fwd_s3_rd);
    assign hzd_rs2_s4 = hit(s1_rs2_addr, gpr_rd);

    // Any unfinished load feeding a source stalls decode
    assign s1_bubble = (fwd_s2_load && (hzd_rs1_s2 || hzd_rs2_s2)) ||
                       (fwd_s3_load && (hzd_rs1_s3 || hzd_rs2_s3)) ||
                       (fwd_s4_load && (hzd_rs1_s4 || hzd_rs2_s4));

    // Youngest first; writeback only counts on its write cycle
    assign fwd_rs1_rdata = hzd_rs1_s2             ? fwd_s2_wdata :
                           hzd_rs1_s3             ? fwd_s3_wdata :
                           hzd_rs1_s4 && gpr_wen  ? gpr_wdata    :
                                                    s1_rs1_rdata;

    assign fwd_rs2_rdata = hzd_rs2_s2             ? fwd_s2_wdata :
                           hzd_rs2_s3             ? fwd_s3_wdata :
                           hzd_rs2_s4 && gpr_wen  ? gpr_wdata    :
                                                    s1_rs2_rdata;

endmodule

`default_nettype wire

// ==== design/pipe_execute.sv ====
/*
 * Execute stage. ALU and address adder feeding the execute-to-memory
 * register, plus the execute forwarding outputs.
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_execute (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire                      s2_valid,
    input  wire pipe_pkg::opcode_e   s2_op,
    input  wire pipe_pkg::gpr_addr_t s2_rd,
    input  wire pipe_pkg::word_t     s2_opr_a,
    input  wire pipe_pkg::word_t     s2_opr_b,
    input  wire pipe_pkg::word_t     s2_imm,
    input  wire pipe_pkg::word_t     s2_instr,
    input  wire                      s3_busy,       // Memory holding
    output logic                     s2_busy,
    output pipe_pkg::gpr_addr_t      fwd_s2_rd,
    output pipe_pkg::word_t          fwd_s2_wdata,
    output logic                     fwd_s2_load,
    output logic                     s3_valid,
    output pipe_pkg::opcode_e        s3_op,
    output pipe_pkg::gpr_addr_t      s3_rd,
    output pipe_pkg::word_t          s3_result,     // ALU value or address
    output pipe_pkg::word_t          s3_store_data,
    output pipe_pkg::word_t          s3_instr
);

    pipe_pkg::word_t addr_sum;                      // rs1 + imm
    pipe_pkg::word_t alu_result;

    assign addr_sum = s2_opr_a + s2_imm;

    always_comb begin
        case (s2_op)
            pipe_pkg::OP_ADD: alu_result = s2_opr_a + s2_opr_b;
            pipe_pkg::OP_SUB: alu_result = s2_opr_a - s2_opr_b;
            pipe_pkg::OP_AND: alu_result = s2_opr_a & s2_opr_b;
            pipe_pkg::OP_OR:  alu_result = s2_opr_a | s2_opr_b;
            pipe_pkg::OP_XOR: alu_result = s2_opr_a ^ s2_opr_b;
            pipe_pkg::OP_ADDI,
            pipe_pkg::OP_LW,
            pipe_pkg::OP_SW:  alu_result = addr_sum;  // Shared adder
            default:          alu_result = '0;
        endcase
    end

    assign s2_busy = s2_valid && s3_busy;

    // Stores and NOPs write nothing, so they report r0
    assign fwd_s2_rd    = (s2_valid && !(s2_op inside {pipe_pkg::OP_NOP, pipe_pkg::OP_SW}))
                          ? s2_rd : '0;
    assign fwd_s2_wdata = alu_result;
    assign fwd_s2_load  = s2_valid && s2_op == pipe_pkg::OP_LW;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s3_valid <= 1'b0;
        end else if (!s3_busy) begin
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s2_valid && !s3_busy) begin
            s3_op         <= s2_op;
            s3_rd         <= s2_rd;
            s3_result     <= alu_result;
            s3_store_data <= s2_opr_b;
            s3_instr      <= s2_instr;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_memory.sv ====
/*
 * Memory stage. Issues one load or store on the data port and holds it
 * until granted; ALU results pass straight to writeback.
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_memory (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire                      s3_valid,
    input  wire pipe_pkg::opcode_e   s3_op,
    input  wire pipe_pkg::gpr_addr_t s3_rd,
    input  wire pipe_pkg::word_t     s3_result,
    input  wire pipe_pkg::word_t     s3_store_data,
    input  wire pipe_pkg::word_t     s3_instr,
    input  wire                      dmem_gnt,
    input  wire                      s4_busy,       // Writeback waiting
    output logic                     s3_busy,
    output pipe_pkg::gpr_addr_t      fwd_s3_rd,
    output pipe_pkg::word_t          fwd_s3_wdata,
    output logic                     fwd_s3_load,
    output logic                     dmem_req,
    output logic                     dmem_wen,
    output pipe_pkg::word_t          dmem_addr,
    output pipe_pkg::word_t          dmem_wdata,
    output logic                     s4_valid,
    output pipe_pkg::opcode_e        s4_op,
    output pipe_pkg::gpr_addr_t      s4_rd,
    output pipe_pkg::word_t          s4_result,
    output pipe_pkg::word_t          s4_instr
);

    logic is_mem;
    logic advance;                                  // Content moves on

    assign is_mem = s3_op inside {pipe_pkg::OP_LW, pipe_pkg::OP_SW};

    // No request while the previous access still waits for its receive
    assign dmem_req   = s3_valid && is_mem && !s4_busy;
    assign dmem_wen   = s3_op == pipe_pkg::OP_SW;
    assign dmem_addr  = s3_result;                  // Held in s3 until granted
    assign dmem_wdata = s3_store_data;

    assign s3_busy = s3_valid && (s4_busy || (is_mem && !dmem_gnt));
    assign advance = s3_valid && !s3_busy;

    assign fwd_s3_rd    = (s3_valid && !(s3_op inside {pipe_pkg::OP_NOP, pipe_pkg::OP_SW}))
                          ? s3_rd : '0;
    assign fwd_s3_wdata = s3_result;
    assign fwd_s3_load  = s3_valid && s3_op == pipe_pkg::OP_LW;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s4_valid <= 1'b0;
        end else if (!s4_busy) begin
            s4_valid <= advance;                    // Empty while awaiting grant
        end
    end

    always_ff @(posedge g_clk) begin
        if (advance) begin
            s4_op     <= s3_op;
            s4_rd     <= s3_rd;
            s4_result <= s3_result;
            s4_instr  <= s3_instr;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_writeback.sv ====
/*
 * Writeback stage. Waits for the receive of a load or store, writes rd
 * and retires every instruction on the trace port in program order.
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_writeback (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire                      s4_valid,
    input  wire pipe_pkg::opcode_e   s4_op,
    input  wire pipe_pkg::gpr_addr_t s4_rd,
    input  wire pipe_pkg::word_t     s4_result,
    input  wire pipe_pkg::word_t     s4_instr,
    input  wire                      dmem_recv,     // Response strobe
    input  wire pipe_pkg::word_t     dmem_rdata,
    input  wire                      dmem_error,
    output logic                     s4_busy,
    output logic                     fwd_s4_load,
    output logic                     gpr_wen,
    output pipe_pkg::gpr_addr_t      gpr_rd,        // Also the hazard tag
    output pipe_pkg::word_t          gpr_wdata,
    output logic                     trs_valid,
    output pipe_pkg::word_t          trs_instr,
    output pipe_pkg::gpr_addr_t      trs_rd,
    output pipe_pkg::word_t          trs_wdata,
    output logic                     trs_error
);

    logic is_mem;
    logic writes_rd;                                // Op type has a result
    logic retire;
    logic mem_err;

    assign is_mem    = s4_op inside {pipe_pkg::OP_LW, pipe_pkg::OP_SW};
    assign writes_rd = !(s4_op inside {pipe_pkg::OP_NOP, pipe_pkg::OP_SW});

    assign s4_busy     = s4_valid && is_mem && !dmem_recv;
    assign fwd_s4_load = s4_valid && s4_op == pipe_pkg::OP_LW && !dmem_recv;
    assign retire      = s4_valid && !s4_busy;
    assign mem_err     = is_mem && dmem_error;      // Sampled with recv

    assign gpr_rd    = (s4_valid && writes_rd) ? s4_rd : '0;
    assign gpr_wdata = (s4_op == pipe_pkg::OP_LW) ? dmem_rdata : s4_result;
    assign gpr_wen   = retire && writes_rd && s4_rd != '0 && !mem_err;  // Fault keeps rd

    always_ff @(posedge g_clk) begin
        if (rst) begin
            trs_valid <= 1'b0;
        end else begin
            trs_valid <= retire;                    // One pulse per instruction
        end
    end

    always_ff @(posedge g_clk) begin
        if (retire) begin
            trs_instr <= s4_instr;
            trs_rd    <= gpr_wen ? gpr_rd : '0;
            trs_wdata <= gpr_wen ? gpr_wdata : '0;
            trs_error <= mem_err;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_top.sv ====
/*
 * Top of the four stage integer pipeline. Decode, execute, memory and
 * writeback sit around the register file and the hazard unit. Words
 * enter on the issue port, loads and stores leave on the data port.
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
    input  wire                  g_clk,          // Global clock
    input  wire                  rst,            // Synchronous active high reset
    input  wire                  issue_valid,    // Issue word present
    input  wire pipe_pkg::word_t issue_instr,    // Issued instruction word
    output logic                 issue_busy,     // Issue port stalled
    output logic                 dmem_req,       // Memory request
    output logic                 dmem_wen,       // Store when high
    output pipe_pkg::word_t      dmem_addr,      // Byte address
    output pipe_pkg::word_t      dmem_wdata,     // Store data
    input  wire                  dmem_gnt,       // Request accepted
    input  wire                  dmem_recv,      // Response strobe
    input  wire pipe_pkg::word_t dmem_rdata,     // Load data
    input  wire                  dmem_error,     // Access fault
    output logic                 trs_valid,      // Instruction retired
    output pipe_pkg::word_t      trs_instr,      // Retired word
    output pipe_pkg::gpr_addr_t  trs_rd,         // Written register
    output pipe_pkg::word_t      trs_wdata,      // Written value
    output logic                 trs_error       // Memory fault on retire
);

    // ---------------------------------------------------------------------
    // Stage links

    pipe_pkg::gpr_addr_t s1_rs1_addr;
    pipe_pkg::gpr_addr_t s1_rs2_addr;
    pipe_pkg::word_t     s1_rs1_rdata;   // Raw register file reads
    pipe_pkg::word_t     s1_rs2_rdata;
    pipe_pkg::word_t     fwd_rs1_rdata;  // After forwarding
    pipe_pkg::word_t     fwd_rs2_rdata;
    logic                s1_bubble;

    logic                s2_valid;
    logic                s2_busy;
    pipe_pkg::opcode_e   s2_op;
    pipe_pkg::gpr_addr_t s2_rd;
    pipe_pkg::word_t     s2_opr_a;
    pipe_pkg::word_t     s2_opr_b;
    pipe_pkg::word_t     s2_imm;
    pipe_pkg::word_t     s2_instr;
    pipe_pkg::gpr_addr_t fwd_s2_rd;
    pipe_pkg::word_t     fwd_s2_wdata;
    logic                fwd_s2_load;

    logic                s3_valid;
    logic                s3_busy;
    pipe_pkg::opcode_e   s3_op;
    pipe_pkg::gpr_addr_t s3_rd;
    pipe_pkg::word_t     s3_result;      // ALU value or address
    pipe_pkg::word_t     s3_store_data;
    pipe_pkg::word_t     s3_instr;
    pipe_pkg::gpr_addr_t fwd_s3_rd;
    pipe_pkg::word_t     fwd_s3_wdata;
    logic                fwd_s3_load;

    logic                s4_valid;
    logic                s4_busy;
    pipe_pkg::opcode_e   s4_op;
    pipe_pkg::gpr_addr_t s4_rd;
    pipe_pkg::word_t     s4_result;
    pipe_pkg::word_t     s4_instr;
    logic                fwd_s4_load;    // Writeback waiting on load data
    logic                gpr_wen;
    pipe_pkg::gpr_addr_t gpr_rd;
    pipe_pkg::word_t     gpr_wdata;

    // ---------------------------------------------------------------------
    // Instances

    pipe_decode      u_decode      (.*);
    pipe_hazard_ctrl u_hazard_ctrl (.*);
    pipe_execute     u_execute     (.*);
    pipe_memory      u_memory      (.*);
    pipe_writeback   u_writeback   (.*);

    pipe_gprs u_gprs (
        .g_clk     (g_clk       ),
        .rst       (rst         ),
        .rs1_addr  (s1_rs1_addr ), // Read port 1
        .rs2_addr  (s1_rs2_addr ), // Read port 2
        .rd_wen    (gpr_wen     ), // Write from writeback
        .rd_addr   (gpr_rd      ),
        .rd_wdata  (gpr_wdata   ),
        .rs1_rdata (s1_rs1_rdata),
        .rs2_rdata (s1_rs2_rdata)
    );

endmodule

`default_nettype wire

// ==== tests/tb_pipe_top.sv ====
/*
 * Testbench for the integer pipeline. Issues the words of the test data
 * file back to back, answers the data port from a small memory model with
 * random grant and receive delays, and checks every retire in order.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_top;

    localparam int          MAX_LINES    = 64;
    localparam int          ISSUE_LIMIT  = 200;     // Cycles per accepted word
    localparam int          DRAIN_LIMIT  = 2000;    // Cycles until the last retire
    localparam int          QUIET_CYCLES = 50;      // Idle window after the last retire
    localparam logic [31:0] END_MARK     = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {M_IDLE, M_GNT, M_RECV} mem_state_e;

    logic                g_clk;
    logic                rst         = 1'b1;
    logic                issue_valid = 1'b0;
    pipe_pkg::word_t     issue_instr = '0;
    logic                issue_busy;
    logic                dmem_req;
    logic                dmem_wen;
    pipe_pkg::word_t     dmem_addr;
    pipe_pkg::word_t     dmem_wdata;
    logic                dmem_gnt    = 1'b0;
    logic                dmem_recv   = 1'b0;
    pipe_pkg::word_t     dmem_rdata  = '0;
    logic                dmem_error  = 1'b0;
    logic                trs_valid;
    pipe_pkg::word_t     trs_instr;
    pipe_pkg::gpr_addr_t trs_rd;
    pipe_pkg::word_t     trs_wdata;
    logic                trs_error;

    logic [31:0]         vec [0:4*MAX_LINES-1];    // Four columns per data line
    int                  n_lines;
    int                  n_retired   = 0;
    logic [31:0]         seed_val;
    int                  delay_tab [0:255];         // Pre-drawn 0..3 cycle delays

    pipe_pkg::word_t     mem [0:255];               // Word addressed by addr[9:2]
    mem_state_e          m_state     = M_IDLE;
    int                  m_cnt       = 0;
    logic [7:0]          m_draw      = '0;
    logic                req_s;                     // Port sampled mid cycle
    logic                wen_s;
    pipe_pkg::word_t     addr_s;
    pipe_pkg::word_t     wdata_s;
    logic                lat_wen;
    pipe_pkg::word_t     lat_addr;
    pipe_pkg::word_t     lat_wdata;

    pipe_top u_pipe_top (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                  // 4 ns period
    end

    // ------------------------------------------------------------------
    // Failure handling and compares

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t got,
                              input pipe_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_rd(input string name, input pipe_pkg::gpr_addr_t got,
                            input pipe_pkg::gpr_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // Data memory model

    always @(negedge g_clk) begin
        req_s   <= dmem_req;                        // Stable between edges
        wen_s   <= dmem_wen;
        addr_s  <= dmem_addr;
        wdata_s <= dmem_wdata;
    end

    always @(posedge g_clk) begin
        if (rst) begin
            m_state    <= M_IDLE;
            dmem_gnt   <= 1'b0;
            dmem_recv  <= 1'b0;
            dmem_error <= 1'b0;
            dmem_rdata <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= pipe_pkg::word_t'(i * 4) ^ 32'h5A5A_0000;  // Byte address pattern
            end
        end else begin
            case (m_state)
                M_IDLE: begin
                    dmem_recv  <= 1'b0;
                    dmem_error <= 1'b0;
                    if (req_s) begin
                        m_cnt   <= delay_tab[m_draw];   // Grant delay
                        m_draw  <= m_draw + 8'd1;
                        m_state <= M_GNT;
                    end
                end
                M_GNT: begin
                    if (!req_s) begin
                        abort_run("Data request dropped before it was granted");
                    end else if (dmem_gnt) begin    // Access taken at this edge
                        dmem_gnt  <= 1'b0;
                        lat_wen   <= wen_s;
                        lat_addr  <= addr_s;
                        lat_wdata <= wdata_s;
                        m_cnt     <= delay_tab[m_draw]; // Receive delay
                        m_draw    <= m_draw + 8'd1;
                        m_state   <= M_RECV;
                    end else if (m_cnt == 0) begin
                        dmem_gnt <= 1'b1;
                    end else begin
                        m_cnt <= m_cnt - 1;
                    end
                end
                default: begin
                    if (m_cnt != 0) begin
                        m_cnt <= m_cnt - 1;
                    end else if (lat_addr >= 32'h0000_0400) begin
                        dmem_recv  <= 1'b1;         // Out of range
                        dmem_error <= 1'b1;
                        dmem_rdata <= ~lat_addr;
                        m_state    <= M_IDLE;
                    end else begin
                        dmem_recv  <= 1'b1;
                        dmem_error <= 1'b0;
                        dmem_rdata <= mem[lat_addr[9:2]];
                        if (lat_wen) begin
                            mem[lat_addr[9:2]] <= lat_wdata;
                        end
                        m_state    <= M_IDLE;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Retire checker, one expected line per trace pulse

    always @(negedge g_clk) begin
        if (!rst && trs_valid) begin
            if (n_retired >= n_lines) begin
                abort_run("Retire seen after the last expected instruction");
            end else begin
                check_word("trs_instr", trs_instr, vec[4*n_retired]);
                check_rd("trs_rd", trs_rd, vec[4*n_retired+1][4:0]);
                check_word("trs_wdata", trs_wdata, vec[4*n_retired+2]);
                check_bit("trs_error", trs_error, vec[4*n_retired+3][0]);
                n_retired <= n_retired + 1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Issue driver and run control

    task automatic issue_word(input pipe_pkg::word_t word);
        logic busy;
        int   waited;
        issue_valid <= 1'b1;
        issue_instr <= word;
        busy   = 1'b1;
        waited = 0;
        while (busy) begin
            @(negedge g_clk);
            busy = issue_busy;                      // Taken at next edge if low
            @(posedge g_clk);
            waited++;
            if (busy && waited > ISSUE_LIMIT) begin
                abort_run($sformatf("Timeout waiting for issue of word %h", word));
            end
        end
    endtask

    task automatic wait_all_retired();
        int waited;
        waited = 0;
        while (n_retired < n_lines) begin
            @(posedge g_clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("Timeout waiting for the last instruction to retire");
            end
        end
    endtask

    initial begin
        seed_val = $urandom(32'h759c_9175);
        for (int i = 0; i < 256; i++) begin
            delay_tab[i] = $urandom_range(3, 0);
        end
        $display("Random seed 759c9175, first draw %h", seed_val);
        for (int i = 0; i < 4*MAX_LINES; i++) begin
            vec[i] = END_MARK;                      // Marks the end of the file
        end
        $readmemh("tests/pipe_testdata.txt", vec);
        n_lines = 0;
        while (n_lines < MAX_LINES && vec[4*n_lines] != END_MARK) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            abort_run("Test data file holds no instructions");
        end

        repeat (16) @(posedge g_clk);
        rst <= 1'b0;
        @(negedge g_clk);
        check_bit("issue_busy", issue_busy, 1'b0);  // Idle after reset
        check_bit("dmem_req", dmem_req, 1'b0);
        check_bit("trs_valid", trs_valid, 1'b0);
        @(posedge g_clk);

        for (int i = 0; i < n_lines; i++) begin
            issue_word(vec[4*i]);
        end
        issue_valid <= 1'b0;
        issue_instr <= '0;

        wait_all_retired();
        repeat (QUIET_CYCLES) @(posedge g_clk);    // Extra retires caught above
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/pipe_testdata.txt ====
// Columns: instruction word, expected trs_rd, expected trs_wdata, expected trs_error
// One instruction per line in issue order, all values in hex
60800123 01 00000123 0
61001FFB 02 FFFFFFFB 0
11844000 03 0000011E 0
220C2000 04 FFFFFFFB 0
32906000 05 0000011A 0
43142000 06 0000013B 0
53988000 07 FFFFFEC0 0
74000040 08 5A5A0040 0
14A02000 09 5A5A0163 0
8000E080 00 00000000 0
75000080 0A FFFFFEC0 0
8004BFDD 00 00000000 0
75800100 0B 0000011A 0
66000077 0C 00000077 0
76000400 00 00000000 1
61B00001 03 00000078 0
60040055 00 00000000 0
12000000 04 00000000 0
00000000 00 00000000 0
F0800123 00 00000000 0
62840000 05 00000123 0
63000200 06 00000200 0
80184004 00 00000000 0
73980004 07 FFFFFFFB 0
74180000 08 5A5A0200 0
24A0E000 09 5A5A0205 0
80002800 00 00000000 1
55254000 0A A5A5FCC5 0

// ==== files.f ====
+incdir+include
design/pipe_pkg.sv
design/pipe_gprs.sv
design/pipe_decode.sv
design/pipe_hazard_ctrl.sv
design/pipe_execute.sv
design/pipe_memory.sv
design/pipe_writeback.sv
design/pipe_top.sv
tests/tb_pipe_top.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

SIM = obj_dir/Vtb_pipe_top

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

$(SIM): files.f design/*.sv include/*.svh tests/tb_pipe_top.sv tests/pipe_testdata.txt
	verilator --binary --timing -j 0 -f files.f --top-module tb_pipe_top

lint:
	verilator --lint-only -Wall -f files.f --timing --top-module pipe_top

clean:
	rm -rf obj_dir sim.log
